// File: bench/tb_pipe_trace.sv
/*
  directed tests for the pipeline trace unit, driven 1 ns after each rising edge
  a queue of expected tags with fetch cycles models the pipeline at each falling edge
  counter reads are only made while the pipeline is drained
*/

`timescale 1ns/10ps

module tb_pipe_trace import trace_pkg::*; ();

    // reset, six tests with their drains, and a margin
    localparam int cycle_limit = 10 + 31 + 71 + 73 + 48 + 25 + 91 + 100;

    logic             clk = 1'b0;
    logic             rst;
    logic             stall;
    logic             flush;
    logic             cfg_we;
    logic [1:0]       cfg_addr;
    logic [cnt_w-1:0] cfg_wdata;
    logic [cnt_w-1:0] cfg_rdata;
    logic             done;
    tag_t             done_tag;
    cyc_t             done_fetch_cyc;
    cyc_t             done_decode_cyc;
    cyc_t             done_exec_cyc;
    cyc_t             done_mem_cyc;
    cyc_t             done_wb_cyc;

    // expected tags in flight, oldest first, with the cycle they sat in fetch
    tag_t  q_tag [$];
    int    q_fetch [$];
    int    cur_cyc;
    tag_t  next_tag;
    logic  model_en;
    int    exp_flushed;
    int    done_seen;
    int    retired_base = 0;
    string cur_test = "reset";
    int    errors = 0;
    int    mon_errors = 0;
    int    errs_at_start = 0;
    int    tests_run = 0;
    int    tests_bad = 0;
    int    cycles = 0;

    pipe_trace_top dut (.*);

    always #50 clk = ~clk;

    function automatic int check_value(input string what, input int expected, input int actual);
        int bad;
        bad = 0;
        assert (expected == actual) else begin
            $display("mismatch %s %s expected %0d actual %0d", cur_test, what, expected, actual);
            bad = 1;
        end
        return bad;
    endfunction

    ////////////////////
    // reference model
    ////////////////////

    // inputs and outputs are both settled mid cycle
    always @(negedge clk) begin : ref_model
        logic exp_done;
        if (rst) begin
            q_tag.delete();
            q_fetch.delete();
            cur_cyc = 0;
            next_tag = '0;
            model_en = 1'b1;
            exp_flushed = 0;
            done_seen = 0;
        end else begin
            // done comes in the cycle after write-back, fetch + 5
            exp_done = q_fetch.size() > 0 && q_fetch[0] + 5 == cur_cyc;
            assert (done === exp_done) else begin
                $display("mismatch %s done expected %0b actual %0b", cur_test, exp_done, done);
                mon_errors++;
            end
            if (exp_done) begin
                mon_errors += check_value("tag", int'(q_tag[0]), int'(done_tag));
                mon_errors += check_value("fetch stamp", q_fetch[0], int'(done_fetch_cyc));
                mon_errors += check_value("decode stamp", q_fetch[0] + 1, int'(done_decode_cyc));
                mon_errors += check_value("exec stamp", q_fetch[0] + 2, int'(done_exec_cyc));
                mon_errors += check_value("mem stamp", q_fetch[0] + 3, int'(done_mem_cyc));
                mon_errors += check_value("wb stamp", q_fetch[0] + 4, int'(done_wb_cyc));
                void'(q_tag.pop_front());
                void'(q_fetch.pop_front());
            end
            if (done === 1'b1) begin
                done_seen++;
            end
            // coming edge, flush hits fetch (cur_cyc) and decode (cur_cyc - 1)
            if (flush) begin
                for (int i = q_fetch.size() - 1; i >= 0; i--) begin
                    if (q_fetch[i] >= cur_cyc - 1) begin
                        q_tag.delete(i);
                        q_fetch.delete(i);
                        exp_flushed++;
                    end
                end
            end
            // entry sees the enable from before a write at the same edge
            if (model_en && !stall) begin
                q_tag.push_back(next_tag);
                q_fetch.push_back(cur_cyc + 1);
                next_tag = next_tag + 1'b1;
            end
            if (cfg_we) begin
                case (cfg_addr)
                    reg_ctrl:    model_en = cfg_wdata[0];
                    reg_flushed: exp_flushed = 0;
                    default:     ;
                endcase
            end
            cur_cyc++;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("timeout, run still going after %0d cycles", cycle_limit);
            $display("tests failed");
            $finish;
        end
    end

    ////////////////////
    // bus and sequencing
    ////////////////////

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic write_reg(input logic [1:0] addr, input logic [cnt_w-1:0] data);
        cfg_we = 1'b1;
        cfg_addr = addr;
        cfg_wdata = data;
        step();
        cfg_we = 1'b0;
    endtask

    // rdata is registered, valid right after the edge that took the address
    task automatic read_reg(input logic [1:0] addr, output int data);
        cfg_addr = addr;
        step();
        data = int'(cfg_rdata);
    endtask

    // hold off entries until done stays low longer than any instruction takes
    task automatic drain();
        int waited;
        int quiet;
        waited = 0;
        quiet = 0;
        stall = 1'b1;
        flush = 1'b0;
        while (quiet <= num_stages && waited < 4 * num_stages) begin
            step();
            waited++;
            quiet = done ? 0 : quiet + 1;
        end
        assert (quiet > num_stages && q_tag.size() == 0) else begin
            $display("%s: pipeline did not drain within %0d cycles", cur_test, waited);
            errors++;
        end
    endtask

    task automatic start_test(input string name);
        cur_test = name;
        errs_at_start = errors + mon_errors;
    endtask

    task automatic report_test();
        tests_run++;
        if (errors + mon_errors == errs_at_start) begin
            $display("test %s: ok", cur_test);
        end else begin
            tests_bad++;
            $display("test %s: %0d errors", cur_test, errors + mon_errors - errs_at_start);
        end
    endtask

    ////////////////////
    // tests
    ////////////////////

    task automatic test_free_run();
        start_test("free_run");
        stall = 1'b0;
        repeat (20) step();
        drain();
        report_test();
    endtask

    task automatic test_stall();
        start_test("stall");
        repeat (60) begin
            stall = ($urandom % 2) == 0;
            step();
        end
        drain();
        report_test();
    endtask

    task automatic test_flush();
        int rd;
        start_test("flush");
        write_reg(reg_flushed, '0);
        repeat (60) begin
            stall = ($urandom % 4) == 0;
            flush = ($urandom % 4) == 0;
            step();
        end
        drain();
        read_reg(reg_flushed, rd);
        errors += check_value("flushed count", exp_flushed, rd);
        report_test();
    endtask

    task automatic test_enable();
        int rd;
        int waited;
        int seen_off;
        tag_t resume_tag;
        start_test("enable");
        stall = 1'b0;
        repeat (10) step();
        write_reg(reg_ctrl, cnt_w'(0));
        // the in-flight instructions leave within six cycles
        repeat (12) step();
        // with capture off and no stall nothing more may complete
        seen_off = done_seen;
        repeat (num_stages + 1) step();
        errors += check_value("completions with capture off", seen_off, done_seen);
        read_reg(reg_ctrl, rd);
        errors += check_value("ctrl readback", 0, rd);
        resume_tag = next_tag;
        write_reg(reg_ctrl, cnt_w'(1));
        waited = 0;
        while (!done && waited < 3 * num_stages) begin
            step();
            waited++;
        end
        assert (done) else begin
            $display("%s: no completion after capture was switched back on", cur_test);
            errors++;
        end
        errors += check_value("resume tag", int'(resume_tag), int'(done_tag));
        drain();
        report_test();
    endtask

    task automatic test_counters();
        int rd;
        start_test("counters");
        read_reg(reg_retired, rd);
        errors += check_value("retired count", done_seen - retired_base, rd);
        write_reg(reg_retired, '1);
        retired_base = done_seen;
        write_reg(reg_flushed, '1);
        read_reg(reg_retired, rd);
        errors += check_value("retired after clear", 0, rd);
        read_reg(reg_flushed, rd);
        errors += check_value("flushed after clear", 0, rd);
        stall = 1'b0;
        repeat (6) step();
        flush = 1'b1;
        step();
        drain();
        read_reg(reg_retired, rd);
        errors += check_value("retired count", done_seen - retired_base, rd);
        read_reg(reg_flushed, rd);
        errors += check_value("flushed count", exp_flushed, rd);
        report_test();
    endtask

    task automatic test_wrap();
        int seen_before;
        start_test("wrap");
        seen_before = done_seen;
        stall = 1'b0;
        repeat (80) step();
        drain();
        assert (done_seen - seen_before > trace_depth) else begin
            $display("%s: only %0d completions, tags never wrapped", cur_test,
                     done_seen - seen_before);
            errors++;
        end
        report_test();
    endtask

    initial begin
        void'($urandom(32'hb297b006));
        rst = 1'b1;
        stall = 1'b0;
        flush = 1'b0;
        cfg_we = 1'b0;
        cfg_addr = reg_ctrl;
        cfg_wdata = '0;
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;
        test_free_run();
        test_stall();
        test_flush();
        test_enable();
        test_counters();
        test_wrap();
        $display("%0d tests run, %0d with errors, %0d check errors", tests_run, tests_bad,
                 errors + mon_errors);
        if (errors + mon_errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// File: design/pipe_trace_top.sv
/*
  trace unit top, plain ports only
  completion record fields are valid while done is high, nothing holds them
*/

`timescale 1ns/10ps

module pipe_trace_top import trace_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    // cpu status
    input  logic             stall,
    input  logic             flush,
    // config bus
    input  logic             cfg_we,
    input  logic [1:0]       cfg_addr,
    input  logic [cnt_w-1:0] cfg_wdata,
    output logic [cnt_w-1:0] cfg_rdata,
    // completion record
    output logic             done,
    output tag_t             done_tag,
    output cyc_t             done_fetch_cyc,
    output cyc_t             done_decode_cyc,
    output cyc_t             done_exec_cyc,
    output cyc_t             done_mem_cyc,
    output cyc_t             done_wb_cyc
);

    // tracker to store
    logic [num_stages-1:0] stage_valid;
    tag_t                  stage_tag [num_stages];
    cyc_t                  cycle;

    // tracker and register block
    logic       retire;
    logic [1:0] flush_count;
    logic       enable;

    trace_rec_t rec;

    stage_tracker u_tracker (
        .clk         (clk),
        .rst         (rst),
        .stall       (stall),
        .flush       (flush),
        .enable      (enable),
        .stage_valid (stage_valid),
        .stage_tag   (stage_tag),
        .cycle       (cycle),
        .retire      (retire),
        .flush_count (flush_count)
    );

    stamp_store u_store (
        .clk         (clk),
        .rst         (rst),
        .stage_valid (stage_valid),
        .stage_tag   (stage_tag),
        .cycle       (cycle),
        .done        (done),
        .rec         (rec)
    );

    trace_regs u_regs (
        .clk         (clk),
        .rst         (rst),
        .cfg_we      (cfg_we),
        .cfg_addr    (cfg_addr),
        .cfg_wdata   (cfg_wdata),
        .cfg_rdata   (cfg_rdata),
        .retire      (retire),
        .flush_count (flush_count),
        .enable      (enable)
    );

    // split the record onto the output ports
    assign done_tag        = rec.tag;
    assign done_fetch_cyc  = rec.fetch_cyc;
    assign done_decode_cyc = rec.decode_cyc;
    assign done_exec_cyc   = rec.exec_cyc;
    assign done_mem_cyc    = rec.mem_cyc;
    assign done_wb_cyc     = rec.wb_cyc;

endmodule

// File: design/stage_tracker.sv
/*
  follows instructions through the five stages by tag
  stall only blocks entry into fetch, the back stages always advance
  flush drops fetch and decode, a new fetch at the same edge still enters
*/

`timescale 1ns/10ps

module stage_tracker import trace_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  stall,
    input  logic                  flush,
    input  logic                  enable,
    output logic [num_stages-1:0] stage_valid,
    output tag_t                  stage_tag [num_stages],
    output cyc_t                  cycle,
    output logic                  retire,
    output logic [1:0]            flush_count
);

    // next tag to hand out on entry
    tag_t next_tag;
    // a new instruction enters fetch at this edge
    logic entry;

    assign entry = enable && !stall;

    ////////////////////
    // cycle counter
    ////////////////////

    // reads 0 in the first cycle after reset is released
    always_ff @(posedge clk) begin
        if (rst) begin
            cycle <= '0;
        end else begin
            cycle <= cycle + 1'b1;
        end
    end

    ////////////////////
    // tag allocation
    ////////////////////

    // tags advance per entry, flushed instructions still consume one
    always_ff @(posedge clk) begin
        if (rst) begin
            next_tag <= '0;
        end else if (entry) begin
            next_tag <= next_tag + 1'b1;
        end
    end

    ////////////////////
    // valid chain
    ////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            stage_valid <= '0;
        end else begin
            stage_valid[stage_fetch]  <= entry;
            // the two youngest stages are killed by flush
            stage_valid[stage_decode] <= stage_valid[stage_fetch] && !flush;
            stage_valid[stage_exec]   <= stage_valid[stage_decode] && !flush;
            // back stages move unconditionally
            stage_valid[stage_mem]    <= stage_valid[stage_exec];
            stage_valid[stage_wb]     <= stage_valid[stage_mem];
        end
    end

    ////////////////////
    // tag chain
    ////////////////////

    // payload only, qualified by the valid chain
    always_ff @(posedge clk) begin
        stage_tag[stage_fetch] <= next_tag;
        for (int s = 1; s < num_stages; s++) begin
            stage_tag[s] <= stage_tag[s-1];
        end
    end

    // instruction in write-back leaves at the next edge
    assign retire = stage_valid[stage_wb];

    // how many live instructions this flush throws away
    assign flush_count = flush
        ? ({1'b0, stage_valid[stage_fetch]} + {1'b0, stage_valid[stage_decode]})
        : 2'd0;

    ////////////////////
    // checks
    ////////////////////

    // only fetch and decode can be counted as flushed
    a_flush_count_max: assert property (
        @(posedge clk) disable iff (rst)
        flush_count <= 2'd2
    ) else $error("flush_count %0d exceeds two", flush_count);

    // two valid neighbours entered on consecutive edges, so their tags differ by one
    for (genvar s = 1; s < num_stages; s++) begin : g_tag_order
        a_tag_consecutive: assert property (
            @(posedge clk) disable iff (rst)
            (stage_valid[s-1] && stage_valid[s]) |->
                (tag_t'(stage_tag[s-1] - stage_tag[s]) == tag_t'(1))
        ) else $error("stage %0d tag not one behind stage %0d", s, s - 1);
    end

endmodule

// File: design/stamp_store.sv
/*
  tag-indexed stamp memory, one row per stage before write-back
  the write-back stamp is taken straight from the counter on retirement
  no back-pressure, rec is only meaningful while done is high
*/

`timescale 1ns/10ps

module stamp_store import trace_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [num_stages-1:0] stage_valid,
    input  tag_t                  stage_tag [num_stages],
    input  cyc_t                  cycle,
    output logic                  done,
    output trace_rec_t            rec
);

    // stamps for fetch through mem, write-back needs no storage
    cyc_t stamp_mem [stage_wb][trace_depth];

    // tag leaving write-back
    tag_t wb_tag;

    assign wb_tag = stage_tag[stage_wb];

    ////////////////////
    // stamp writes
    ////////////////////

    // each stage owns its own row, so writes never collide
    always_ff @(posedge clk) begin
        for (int s = 0; s < stage_wb; s++) begin
            if (stage_valid[s]) begin
                stamp_mem[s][stage_tag[s]] <= cycle;
            end
        end
    end

    ////////////////////
    // record assembly
    ////////////////////

    // one-cycle pulse, the cycle after write-back
    always_ff @(posedge clk) begin
        if (rst) begin
            done <= 1'b0;
        end else begin
            done <= stage_valid[stage_wb];
        end
    end

    // mem stamp for wb_tag was written at the previous edge, so it is visible here
    always_ff @(posedge clk) begin
        if (stage_valid[stage_wb]) begin
            rec.tag        <= wb_tag;
            rec.fetch_cyc  <= stamp_mem[stage_fetch][wb_tag];
            rec.decode_cyc <= stamp_mem[stage_decode][wb_tag];
            rec.exec_cyc   <= stamp_mem[stage_exec][wb_tag];
            rec.mem_cyc    <= stamp_mem[stage_mem][wb_tag];
            // write-back stamp is the current count
            rec.wb_cyc     <= cycle;
        end
    end

    ////////////////////
    // checks
    ////////////////////

    // an instruction spends exactly one cycle per stage,
    // so its stamp in the stage behind is one less than now
    for (genvar s = 1; s < num_stages; s++) begin : g_stamp_step
        a_stamp_step: assert property (
            @(posedge clk) disable iff (rst)
            stage_valid[s] |->
                (cyc_t'(cycle - stamp_mem[s-1][stage_tag[s]]) == cyc_t'(1))
        ) else $error("tag %0d stage %0d stamp not one after previous stage",
                      stage_tag[s], s);
    end

endmodule

// File: design/trace_pkg.sv
/*
  shared widths, stage indices, register map and completion record
  tags are tag_w bits wide, so at most 2**tag_w instructions can be told apart
  cycle stamps wrap silently at cyc_w bits
*/

package trace_pkg;

    ////////////////////
    // pipeline shape
    ////////////////////

    localparam int num_stages = 5;

    // stage indices, youngest first
    localparam int stage_fetch  = 0;
    localparam int stage_decode = 1;
    localparam int stage_exec   = 2;
    localparam int stage_mem    = 3;
    localparam int stage_wb     = 4;

    ////////////////////
    // widths
    ////////////////////

    localparam int tag_w       = 6;
    // one store entry per possible tag
    localparam int trace_depth = 2 ** tag_w;
    localparam int cyc_w       = 16;
    localparam int cnt_w       = 16;

    // register addresses on the 2-bit config bus
    localparam logic [1:0] reg_ctrl    = 2'd0;
    localparam logic [1:0] reg_retired = 2'd1;
    localparam logic [1:0] reg_flushed = 2'd2;

    typedef logic [tag_w-1:0] tag_t;
    typedef logic [cyc_w-1:0] cyc_t;

    // one completion record, emitted when an instruction leaves write-back
    typedef struct packed {
        tag_t tag;
        cyc_t fetch_cyc;
        cyc_t decode_cyc;
        cyc_t exec_cyc;
        cyc_t mem_cyc;
        cyc_t wb_cyc;
    } trace_rec_t;

endpackage

// File: design/trace_regs.sv
/*
  capture enable plus retired and flushed counters
  writing any value to a counter clears it, a clear beats a same-cycle count
  reads are registered, unknown addresses read zero
*/

`timescale 1ns/10ps

module trace_regs import trace_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    input  logic             cfg_we,
    input  logic [1:0]       cfg_addr,
    input  logic [cnt_w-1:0] cfg_wdata,
    output logic [cnt_w-1:0] cfg_rdata,
    input  logic             retire,
    input  logic [1:0]       flush_count,
    output logic             enable
);

    logic [cnt_w-1:0] retired_cnt;
    logic [cnt_w-1:0] flushed_cnt;

    ////////////////////
    // control register
    ////////////////////

    // capture on by default out of reset
    always_ff @(posedge clk) begin
        if (rst) begin
            enable <= 1'b1;
        end else if (cfg_we && cfg_addr == reg_ctrl) begin
            enable <= cfg_wdata[0];
        end
    end

    ////////////////////
    // counters
    ////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            retired_cnt <= '0;
            flushed_cnt <= '0;
        end else begin
            if (cfg_we && cfg_addr == reg_retired) begin
                retired_cnt <= '0;
            end else if (retire) begin
                retired_cnt <= retired_cnt + 1'b1;
            end
            // up to two instructions dropped per flush
            if (cfg_we && cfg_addr == reg_flushed) begin
                flushed_cnt <= '0;
            end else begin
                flushed_cnt <= flushed_cnt + cnt_w'(flush_count);
            end
        end
    end

    // read data valid the cycle after the address
    always_ff @(posedge clk) begin
        if (rst) begin
            cfg_rdata <= '0;
        end else begin
            case (cfg_addr)
                reg_ctrl:    cfg_rdata <= cnt_w'(enable);
                reg_retired: cfg_rdata <= retired_cnt;
                reg_flushed: cfg_rdata <= flushed_cnt;
                default:     cfg_rdata <= '0;
            endcase
        end
    end

endmodule

// File: list.f
design/trace_pkg.sv
design/stage_tracker.sv
design/stamp_store.sv
design/trace_regs.sv
design/pipe_trace_top.sv
bench/tb_pipe_trace.sv

// File: run.sh
#!/bin/sh
# build and run the trace unit testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f list.f --top-module tb_pipe_trace -o sim_pipe_trace

out=$(./obj_dir/sim_pipe_trace)
echo "$out"

if echo "$out" | grep -qx "all tests passed"; then
    exit 0
fi
exit 1
